// File: src/fetch_cfg_pkg.sv
// Fixed widths of the fetch front, shared by every block
// WID_WIDTH follows NUM_WARPS, so change only NUM_WARPS
`default_nettype none

package fetch_cfg_pkg;

    // ########################################
    // Datapath widths
    // ########################################

    // Program counter, word addressed
    localparam int unsigned PC_WIDTH = 32;

    // One encoded instruction
    localparam int unsigned INST_WIDTH = 32;

    // ########################################
    // SIMT shape
    // ########################################

    // Warps per compute unit
    localparam int unsigned NUM_WARPS = 8;
    // Enough bits to name every warp
    localparam int unsigned WID_WIDTH = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1;

    // Threads per warp, one mask bit each
    localparam int unsigned WARP_WIDTH = 32;

endpackage : fetch_cfg_pkg

`default_nettype wire

// File: src/fetch_types_pkg.sv
// Bundles passed between fetcher, instruction cache and decode
// Field widths come from the config package
`default_nettype none

package fetch_types_pkg;

    // Scalar types
    typedef logic [fetch_cfg_pkg::PC_WIDTH-1:0]   pc_t;
    typedef logic [fetch_cfg_pkg::INST_WIDTH-1:0] inst_t;
    typedef logic [fetch_cfg_pkg::WID_WIDTH-1:0]  wid_t;
    typedef logic [fetch_cfg_pkg::WARP_WIDTH-1:0] act_mask_t;

    // ########################################
    // Fetcher to cache
    // ########################################

    typedef struct packed {
        // Word address of the instruction
        pc_t       pc;
        // Threads that execute it
        act_mask_t act_mask;
        // Issuing warp
        wid_t      warp_id;
    } fetch_req_t;

    // ########################################
    // Cache to decode
    // ########################################

    typedef struct packed {
        pc_t       pc;
        act_mask_t act_mask;
        wid_t      warp_id;
        // Fetched instruction word
        inst_t     inst;
    } dec_out_t;

endpackage : fetch_types_pkg

`default_nettype wire

// File: src/icache_tag_store.sv
// Tags and valid bits of a direct-mapped cache with hit_o one cycle after lookup
// tag_i must hold the looked-up tag while hit_o is used
`timescale 1ns/10ps
`default_nettype none

module icache_tag_store #(
    parameter int unsigned NUM_LINES     = 32,
    parameter int unsigned LINE_IDX_BITS = 1,
    // Derived from the parameters above
    localparam int unsigned IDX_BITS = $clog2(NUM_LINES),
    localparam int unsigned TAG_BITS = fetch_cfg_pkg::PC_WIDTH - LINE_IDX_BITS - IDX_BITS
) (
    input  logic                clk_i,
    input  logic                rst_i,
    // Read strobe in the cycle a request is accepted
    input  logic                lookup_i,
    // Write strobe on the memory response pulse
    input  logic                refill_i,
    input  logic [IDX_BITS-1:0] index_i,
    input  logic [TAG_BITS-1:0] tag_i,
    output logic                hit_o
);

    // ########################################
    // Storage
    // ########################################

    // One tag per line
    logic [TAG_BITS-1:0]  tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;

    // Registered lookup result
    logic [TAG_BITS-1:0]  rd_tag_q;
    logic                 rd_valid_q;

    // Valid bits clear out of reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (refill_i) begin
            valid_q[index_i] <= 1'b1;
        end
    end

    // Tag write on refill
    always_ff @(posedge clk_i) begin
        if (refill_i) begin
            tag_mem[index_i] <= tag_i;
        end
    end

    // ########################################
    // Lookup
    // ########################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_valid_q <= 1'b0;
        end else if (lookup_i) begin
            rd_valid_q <= valid_q[index_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_i) begin
            rd_tag_q <= tag_mem[index_i];
        end
    end

    // Compare against the tag of the request still being handled
    assign hit_o = rd_valid_q && (rd_tag_q == tag_i);

    // Only one miss in flight, so a refill never overlaps a lookup
    a_no_lookup_during_refill : assert property (@(posedge clk_i) disable iff (rst_i)
        !(lookup_i && refill_i)
    ) else $error("Tag store saw lookup and refill in the same cycle");

endmodule : icache_tag_store

`default_nettype wire

// File: src/icache_line_store.sv
// Line data of a direct-mapped cache plus a buffer for the last refill line
// inst_o is valid the cycle after lookup_i or refill_i
`timescale 1ns/10ps
`default_nettype none

module icache_line_store #(
    parameter int unsigned NUM_LINES     = 32,
    parameter int unsigned LINE_IDX_BITS = 1,
    // Derived, not meant to be overridden
    localparam int unsigned IDX_BITS   = $clog2(NUM_LINES),
    localparam int unsigned LINE_WORDS = 1 << LINE_IDX_BITS
) (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  logic                                    lookup_i,
    input  logic                                    refill_i,
    input  logic [IDX_BITS-1:0]                     index_i,
    // Word within the line, sampled on lookup
    input  logic [LINE_IDX_BITS-1:0]                offset_i,
    input  fetch_types_pkg::inst_t [LINE_WORDS-1:0] line_i,
    output fetch_types_pkg::inst_t                  inst_o
);
    import fetch_types_pkg::*;

    typedef inst_t [LINE_WORDS-1:0] line_t;

    // ########################################
    // Storage
    // ########################################

    line_t data_mem [NUM_LINES];

    // Line read on lookup
    line_t rd_line_q;
    // Copy of the last refill line
    line_t refill_buf_q;
    logic [LINE_IDX_BITS-1:0] offset_q;
    // High when inst_o comes from the refill buffer
    logic use_buf_q;

    always_ff @(posedge clk_i) begin
        if (refill_i) begin
            data_mem[index_i] <= line_i;
            refill_buf_q      <= line_i;
        end
        if (lookup_i) begin
            rd_line_q <= data_mem[index_i];
            offset_q  <= offset_i;
        end
    end

    // Source select, last strobe wins
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            use_buf_q <= 1'b0;
        end else if (refill_i) begin
            use_buf_q <= 1'b1;
        end else if (lookup_i) begin
            use_buf_q <= 1'b0;
        end
    end

    // Word select
    assign inst_o = use_buf_q ? refill_buf_q[offset_q] : rd_line_q[offset_q];

endmodule : icache_line_store

`default_nettype wire

// File: src/icache_ctrl.sv
// Instruction cache FSM, one request and at most one miss in flight
// Refill data reaches decode one cycle after the memory response
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl #(
    parameter int unsigned NUM_LINES     = 32,
    parameter int unsigned LINE_IDX_BITS = 1,
    // Derived, not meant to be overridden
    localparam int unsigned IDX_BITS  = $clog2(NUM_LINES),
    localparam int unsigned TAG_BITS  = fetch_cfg_pkg::PC_WIDTH - LINE_IDX_BITS - IDX_BITS,
    localparam int unsigned ADDR_BITS = fetch_cfg_pkg::PC_WIDTH - LINE_IDX_BITS
) (
    input  logic                             clk_i,
    input  logic                             rst_i,

    // Fetcher side
    input  logic                             fe_valid_i,
    input  fetch_types_pkg::fetch_req_t      fe_req_i,
    output logic                             ic_ready_o,

    // Decode side
    input  logic                             dec_ready_i,
    output logic                             ic_valid_o,
    output fetch_types_pkg::dec_out_t        ic_out_o,

    // Memory request and response
    input  logic                             mem_ready_i,
    output logic                             mem_req_o,
    output logic [ADDR_BITS-1:0]             mem_addr_o,
    input  logic                             mem_valid_i,

    // Store results
    input  logic                             hit_i,
    input  fetch_types_pkg::inst_t           inst_i,

    // Store control
    output logic                             lookup_o,
    output logic                             refill_o,
    output logic [IDX_BITS-1:0]              index_o,
    output logic [LINE_IDX_BITS-1:0]         offset_o,
    output logic [TAG_BITS-1:0]              tag_o
);
    import fetch_cfg_pkg::*;
    import fetch_types_pkg::*;

    // ########################################
    // State
    // ########################################

    typedef enum logic [1:0] {
        // No request pending
        ST_IDLE     = 2'd0,
        // Store results ready, decide hit or miss
        ST_HANDLE   = 2'd1,
        // Line requested, waiting for response
        ST_WAIT_MEM = 2'd2,
        // Refilled word on output until decode takes it
        ST_WAIT_DEC = 2'd3
    } state_e;

    state_e state_q, state_d;

    // Request currently being served
    fetch_req_t req_q;

    logic out_taken;

    // ########################################
    // Handshakes
    // ########################################

    // Output valid on a hit, or once the refill line is buffered
    assign ic_valid_o = ((state_q == ST_HANDLE) && hit_i) || (state_q == ST_WAIT_DEC);
    assign out_taken  = ic_valid_o && dec_ready_i;

    // New request when idle or when the current one leaves this cycle
    assign ic_ready_o = (state_q == ST_IDLE) || out_taken;
    assign lookup_o   = fe_valid_i && ic_ready_o;

    // Miss goes out one cycle after acceptance
    assign mem_req_o  = (state_q == ST_HANDLE) && !hit_i;
    // Line address, offset bits dropped
    assign mem_addr_o = req_q.pc[PC_WIDTH-1:LINE_IDX_BITS];

    assign refill_o   = (state_q == ST_WAIT_MEM) && mem_valid_i;

    // ########################################
    // Store addressing
    // ########################################

    // Lookup uses the incoming PC, refill the held one
    assign index_o  = lookup_o ? fe_req_i.pc[LINE_IDX_BITS +: IDX_BITS]
                               : req_q.pc[LINE_IDX_BITS +: IDX_BITS];
    assign offset_o = fe_req_i.pc[LINE_IDX_BITS-1:0];
    // Tag of the held request, compared on hit and written on refill
    assign tag_o    = req_q.pc[PC_WIDTH-1 -: TAG_BITS];

    // Decode bundle, word from whichever store source is live
    always_comb begin
        ic_out_o.pc       = req_q.pc;
        ic_out_o.act_mask = req_q.act_mask;
        ic_out_o.warp_id  = req_q.warp_id;
        ic_out_o.inst     = inst_i;
    end

    // ########################################
    // Next state
    // ########################################

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (lookup_o) begin
                    state_d = ST_HANDLE;
                end
            end
            ST_HANDLE: begin
                // Miss once the memory takes the request
                if (!hit_i && mem_ready_i) begin
                    state_d = ST_WAIT_MEM;
                end
            end
            ST_WAIT_MEM: begin
                if (mem_valid_i) begin
                    state_d = ST_WAIT_DEC;
                end
            end
            default: begin
            end
        endcase
        // Output taken, chain the next request if any
        if (out_taken) begin
            state_d = lookup_o ? ST_HANDLE : ST_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request payload, captured on acceptance only
    always_ff @(posedge clk_i) begin
        if (lookup_o) begin
            req_q <= fe_req_i;
        end
    end

    // ########################################
    // Checks
    // ########################################

    // Responses only for a sent request
    a_resp_when_waiting : assert property (@(posedge clk_i) disable iff (rst_i)
        mem_valid_i |-> (state_q == ST_WAIT_MEM)
    ) else $error("Memory response outside of the wait-for-memory state");

    // Memory request holds until taken
    a_mem_req_stable : assert property (@(posedge clk_i) disable iff (rst_i)
        mem_req_o && !mem_ready_i |=> mem_req_o && $stable(mem_addr_o)
    ) else $error("Memory request changed before it was taken");

    // Decode output holds under back-pressure, word included
    a_dec_out_stable : assert property (@(posedge clk_i) disable iff (rst_i)
        ic_valid_o && !dec_ready_i |=> ic_valid_o && $stable(ic_out_o)
    ) else $error("Decode output changed while stalled");

endmodule : icache_ctrl

`default_nettype wire

// File: src/instruction_cache.sv
// Direct-mapped instruction cache, NUM_LINES must be a power of two
// Hits return after one cycle, misses one cycle after the memory response
`timescale 1ns/10ps
`default_nettype none

module instruction_cache #(
    // Lines in the cache
    parameter int unsigned NUM_LINES     = 32,
    // log2 of words per line, also sets the memory data width
    parameter int unsigned LINE_IDX_BITS = 1
) (
    input  logic                                                 clk_i,
    input  logic                                                 rst_i,

    // Fetcher
    input  logic                                                 fe_valid_i,
    input  fetch_types_pkg::fetch_req_t                          fe_req_i,
    output logic                                                 ic_ready_o,

    // Decode
    output logic                                                 ic_valid_o,
    output fetch_types_pkg::dec_out_t                            ic_out_o,
    input  logic                                                 dec_ready_i,

    // Memory request, line address
    output logic                                                 mem_req_o,
    output logic [fetch_cfg_pkg::PC_WIDTH-LINE_IDX_BITS-1:0]     mem_addr_o,
    input  logic                                                 mem_ready_i,

    // Memory response, one whole line
    input  logic                                                 mem_valid_i,
    input  fetch_types_pkg::inst_t [(1 << LINE_IDX_BITS)-1:0]    mem_data_i
);
    import fetch_cfg_pkg::*;
    import fetch_types_pkg::*;

    localparam int unsigned IDX_BITS = $clog2(NUM_LINES);
    localparam int unsigned TAG_BITS = PC_WIDTH - LINE_IDX_BITS - IDX_BITS;

    // Controller to stores
    logic                     lookup;
    logic                     refill;
    logic [IDX_BITS-1:0]      index;
    logic [LINE_IDX_BITS-1:0] offset;
    logic [TAG_BITS-1:0]      tag;

    // Stores to controller
    logic  hit;
    inst_t inst;

    // ########################################
    // Controller
    // ########################################

    icache_ctrl #(
        .NUM_LINES    (NUM_LINES),
        .LINE_IDX_BITS(LINE_IDX_BITS)
    ) u_ctrl (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .fe_valid_i (fe_valid_i),
        .fe_req_i   (fe_req_i),
        .ic_ready_o (ic_ready_o),
        .dec_ready_i(dec_ready_i),
        .ic_valid_o (ic_valid_o),
        .ic_out_o   (ic_out_o),
        .mem_ready_i(mem_ready_i),
        .mem_req_o  (mem_req_o),
        .mem_addr_o (mem_addr_o),
        .mem_valid_i(mem_valid_i),
        .hit_i      (hit),
        .inst_i     (inst),
        .lookup_o   (lookup),
        .refill_o   (refill),
        .index_o    (index),
        .offset_o   (offset),
        .tag_o      (tag)
    );

    // ########################################
    // Stores
    // ########################################

    icache_tag_store #(
        .NUM_LINES    (NUM_LINES),
        .LINE_IDX_BITS(LINE_IDX_BITS)
    ) u_tag_store (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .lookup_i(lookup),
        .refill_i(refill),
        .index_i (index),
        .tag_i   (tag),
        .hit_o   (hit)
    );

    icache_line_store #(
        .NUM_LINES    (NUM_LINES),
        .LINE_IDX_BITS(LINE_IDX_BITS)
    ) u_line_store (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .lookup_i(lookup),
        .refill_i(refill),
        .index_i (index),
        .offset_i(offset),
        .line_i  (mem_data_i),
        .inst_o  (inst)
    );

endmodule : instruction_cache

`default_nettype wire

// File: testbench/icache_model.svh
// Reference model of the backing memory and the cache tag state
// Included inside tb_icache, needs NUM_LINES, LINE_IDX_BITS, IDX_BITS, line_t
`ifndef ICACHE_MODEL_SVH
`define ICACHE_MODEL_SVH

// ########################################
// Model state
// ########################################

// One valid bit and one tag per line
logic model_valid [NUM_LINES];
pc_t  model_tag   [NUM_LINES];

// 32-bit xorshift, caller keeps its own state
function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// PC without its word offset bits
function automatic pc_t line_addr_of(input pc_t pc);
    return pc >> LINE_IDX_BITS;
endfunction

// Memory contents, odd multiplier keeps every PC distinct
function automatic inst_t mem_word(input pc_t pc);
    return inst_t'(pc * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
endfunction

// Whole line as the memory returns it
function automatic line_t mem_line(input pc_t line_addr);
    line_t line;
    for (int w = 0; w < LINE_WORDS; w++) begin
        line[w] = mem_word((line_addr << LINE_IDX_BITS) | pc_t'(w));
    end
    return line;
endfunction

function automatic void model_reset();
    for (int l = 0; l < NUM_LINES; l++) begin
        model_valid[l] = 1'b0;
        model_tag[l]   = '0;
    end
endfunction

// Direct-mapped lookup, allocates on miss
function automatic logic model_access(input pc_t pc);
    int   idx;
    pc_t  tag;
    logic hit;
    idx = int'(line_addr_of(pc) % NUM_LINES);
    tag = pc >> (LINE_IDX_BITS + IDX_BITS);
    hit = model_valid[idx] && (model_tag[idx] == tag);
    if (!hit) begin
        model_valid[idx] = 1'b1;
        model_tag[idx]   = tag;
    end
    return hit;
endfunction

`endif

// File: testbench/tb_icache.sv
// Random fetch stream against a direct-mapped cache model and a delayed memory
// One request in flight at a time, checked every cycle on the falling edge
`timescale 1ns/10ps
`default_nettype none

module tb_icache;
    import fetch_cfg_pkg::*;
    import fetch_types_pkg::*;

    localparam int unsigned NUM_LINES     = 32;
    localparam int unsigned LINE_IDX_BITS = 1;
    localparam int unsigned IDX_BITS      = $clog2(NUM_LINES);
    localparam int unsigned LINE_WORDS    = 1 << LINE_IDX_BITS;
    localparam int          NUM_REQS      = 400;
    localparam int          CLK_PERIOD_NS = 4;
    localparam int          WATCHDOG_NS   = NUM_REQS * 40 * CLK_PERIOD_NS;
    // Smallest PC step that changes the tag and keeps the index
    localparam pc_t         TAG_STEP      = pc_t'(1) << (LINE_IDX_BITS + IDX_BITS);

    typedef inst_t [LINE_WORDS-1:0] line_t;

    `include "icache_model.svh"

    logic                              clk_i;
    logic                              rst_i;
    logic                              fe_valid_i;
    fetch_req_t                        fe_req_i;
    logic                              ic_ready_o;
    logic                              ic_valid_o;
    dec_out_t                          ic_out_o;
    logic                              dec_ready_i;
    logic                              mem_req_o;
    logic [PC_WIDTH-LINE_IDX_BITS-1:0] mem_addr_o;
    logic                              mem_ready_i;
    logic                              mem_valid_i;
    line_t                             mem_data_i;

    // Monitor bookkeeping for the request in flight
    int       cycle;
    int       outputs_done;
    int       err_count;
    logic     cur_active;
    dec_out_t cur_exp;
    logic     cur_hit;
    int       cur_acc;
    int       cur_resp;
    int       cur_sends;
    logic     cur_seen;
    // Last cycle's stall state
    logic     stall_q;
    dec_out_t held_out;
    logic     mreq_stall_q;
    pc_t      held_addr;

    instruction_cache #(
        .NUM_LINES    (NUM_LINES),
        .LINE_IDX_BITS(LINE_IDX_BITS)
    ) UUT (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .fe_valid_i (fe_valid_i),
        .fe_req_i   (fe_req_i),
        .ic_ready_o (ic_ready_o),
        .ic_valid_o (ic_valid_o),
        .ic_out_o   (ic_out_o),
        .dec_ready_i(dec_ready_i),
        .mem_req_o  (mem_req_o),
        .mem_addr_o (mem_addr_o),
        .mem_ready_i(mem_ready_i),
        .mem_valid_i(mem_valid_i),
        .mem_data_i (mem_data_i)
    );

    // ########################################
    // Failure reporting and compares
    // ########################################

    task automatic halt_run();
        err_count++;
        $display("Test failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic fail_with_reason(input string reason);
        $display("%s", reason);
        halt_run();
    endtask

    task automatic check_dec(input string name, input dec_out_t exp, input dec_out_t act);
        if (act !== exp) begin
            $display("error: %s expected %h actual %h", name, exp, act);
            halt_run();
        end
    endtask

    task automatic check_addr(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            $display("error: %s expected %h actual %h", name, exp, act);
            halt_run();
        end
    endtask

    task automatic check_hit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: %s expected %b actual %b", name, exp, act);
            halt_run();
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_with_reason("Watchdog expired before all requests were answered");
    end

    // ########################################
    // Fetch driver and end of run
    // ########################################

    initial begin
        logic [31:0] rng_fe;
        pc_t         pc;
        pc_t         last_pc;
        rst_i        = 1'b1;
        fe_valid_i   = 1'b0;
        fe_req_i     = '0;
        dec_ready_i  = 1'b1;
        mem_ready_i  = 1'b0;
        mem_valid_i  = 1'b0;
        mem_data_i   = '0;
        cycle        = 0;
        outputs_done = 0;
        err_count    = 0;
        cur_active   = 1'b0;
        stall_q      = 1'b0;
        mreq_stall_q = 1'b0;
        model_reset();
        rng_fe  = 32'd93397;
        last_pc = '0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        // Idle outputs straight out of reset
        @(negedge clk_i);
        check_hit("valid after reset", 1'b0, ic_valid_o);
        check_hit("memory request after reset", 1'b0, mem_req_o);
        check_hit("ready after reset", 1'b1, ic_ready_o);
        @(posedge clk_i);
        #1;
        for (int i = 0; i < NUM_REQS; i++) begin
            rng_fe = xorshift(rng_fe);
            // Same index, two tags, ping-pong to force evictions
            if (i < 8) begin
                pc = (i % 2 == 1) ? pc_t'(32'h12) + TAG_STEP : pc_t'(32'h12);
            end else begin
                case (rng_fe[25:24])
                    2'd0:    pc = last_pc ^ pc_t'(1);
                    2'd1:    pc = last_pc ^ TAG_STEP;
                    default: pc = rng_fe & (4 * TAG_STEP - 1);
                endcase
            end
            fe_req_i.pc      = pc;
            fe_req_i.warp_id = rng_fe[WID_WIDTH-1:0];
            rng_fe = xorshift(rng_fe);
            fe_req_i.act_mask = rng_fe;
            fe_valid_i = 1'b1;
            @(negedge clk_i);
            while (!ic_ready_o) @(negedge clk_i);
            @(posedge clk_i);
            #1;
            fe_valid_i = 1'b0;
            last_pc    = pc;
            // Occasional bubble in the fetch stream
            if (rng_fe[30:29] == 2'b00) begin
                @(posedge clk_i);
                #1;
            end
        end
        wait (outputs_done == NUM_REQS);
        @(negedge clk_i);
        if (err_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "errors were counted");
        end
    end

    // Decode back-pressure, ready three cycles in four
    initial begin
        logic [31:0] rng_dec;
        rng_dec = xorshift(32'd93397 ^ 32'h0000_D3C0);
        wait (rst_i === 1'b0);
        forever begin
            @(posedge clk_i);
            #1;
            rng_dec = xorshift(rng_dec);
            dec_ready_i = rng_dec[1:0] != 2'b00;
        end
    end

    // ########################################
    // Memory responder
    // ########################################

    initial begin
        logic [31:0] rng_mem;
        pc_t         addr;
        int          delay;
        rng_mem = xorshift(32'd93397 ^ 32'h0000_4E40);
        wait (rst_i === 1'b0);
        forever begin
            @(posedge clk_i);
            #1;
            rng_mem = xorshift(rng_mem);
            mem_ready_i = rng_mem[1:0] != 2'b00;
            @(negedge clk_i);
            if (mem_req_o && mem_ready_i) begin
                addr  = pc_t'(mem_addr_o);
                delay = 1 + int'(rng_mem % 6);
                @(posedge clk_i);
                #1;
                mem_ready_i = 1'b0;
                repeat (delay - 1) begin
                    @(posedge clk_i);
                    #1;
                end
                // Single-cycle response pulse
                mem_valid_i = 1'b1;
                mem_data_i  = mem_line(addr);
                @(posedge clk_i);
                #1;
                mem_valid_i = 1'b0;
            end
        end
    end

    // ########################################
    // Monitor, all inputs settled here
    // ########################################

    always @(negedge clk_i) begin
        if (!rst_i) begin
            cycle++;
            if (stall_q) begin
                check_hit("valid under stall", 1'b1, ic_valid_o);
                check_dec("output under stall", held_out, ic_out_o);
            end
            if (mreq_stall_q) begin
                check_hit("memory request held", 1'b1, mem_req_o);
                check_addr("memory address held", held_addr, pc_t'(mem_addr_o));
            end
            // One cycle after acceptance, hit shows data and miss asks memory
            if (cur_active && cycle == cur_acc + 1) begin
                check_hit("output one cycle after hit", cur_hit, ic_valid_o);
                check_hit("memory request after miss", !cur_hit, mem_req_o);
            end
            if (mem_valid_i) begin
                cur_resp = cycle;
            end
            if (ic_valid_o) begin
                if (!cur_active) begin
                    fail_with_reason("Decode output is valid with no request in flight");
                end
                if (!cur_seen) begin
                    cur_seen = 1'b1;
                    if (cycle != (cur_hit ? cur_acc + 1 : cur_resp + 1)) begin
                        fail_with_reason("Decode output did not appear on the expected cycle");
                    end
                end
                check_dec("decode output", cur_exp, ic_out_o);
                if (!dec_ready_i) begin
                    check_hit("fetch ready under stall", 1'b0, ic_ready_o);
                end
            end
            if (mem_req_o && mem_ready_i) begin
                cur_sends++;
                check_addr("memory line address", line_addr_of(cur_exp.pc), pc_t'(mem_addr_o));
                if (cur_hit || cur_sends > 1) begin
                    fail_with_reason("Memory request sent that the cache model does not expect");
                end
            end
            stall_q      = ic_valid_o && !dec_ready_i;
            held_out     = ic_out_o;
            mreq_stall_q = mem_req_o && !mem_ready_i;
            held_addr    = pc_t'(mem_addr_o);
            if (ic_valid_o && dec_ready_i) begin
                if (!cur_hit && cur_sends != 1) begin
                    fail_with_reason("Miss finished without exactly one memory request");
                end
                cur_active = 1'b0;
                outputs_done++;
            end
            // New request, possibly in the same cycle the last one left
            if (fe_valid_i && ic_ready_o) begin
                if (cur_active) begin
                    fail_with_reason("Request accepted while another was still in flight");
                end
                cur_active       = 1'b1;
                cur_exp.pc       = fe_req_i.pc;
                cur_exp.act_mask = fe_req_i.act_mask;
                cur_exp.warp_id  = fe_req_i.warp_id;
                cur_exp.inst     = mem_word(fe_req_i.pc);
                cur_hit          = model_access(fe_req_i.pc);
                cur_acc          = cycle;
                cur_resp         = -100;
                cur_sends        = 0;
                cur_seen         = 1'b0;
            end
        end
    end

endmodule : tb_icache

`default_nettype wire

// File: sim.f
+incdir+testbench
src/fetch_cfg_pkg.sv
src/fetch_types_pkg.sv
src/icache_tag_store.sv
src/icache_line_store.sv
src/icache_ctrl.sv
src/instruction_cache.sv
testbench/tb_icache.sv

// File: Makefile
SIM      = verilator
TOP      = tb_icache
FILELIST = sim.f
FLAGS    = --binary --timing --assert --timescale 1ns/10ps
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
